//--- src.f
logic/cpu900_pkg.sv
logic/cpu900_alu.sv
logic/cpu900_regs.sv
logic/cpu900_pc.sv
logic/cpu900_ramctl.sv
logic/cpu900_ctrl.sv
logic/cpu900.sv
verification/cpu900_mem.sv
verification/cpu900_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu900_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- verification/cpu900_tb.sv
// cpu900 testbench running table programs and checking register dump, flags and memory
`timescale 1ns/10ps

module cpu900_tb;

import cpu900_pkg::*;

localparam int NTESTS  = 4;
localparam int TIMEOUT = 2000;

logic              clk;
logic              rst;
logic              cen;
logic [ADDR_W-1:0] ram_addr;
logic [DATA_W-1:0] ram_dout;
logic [DATA_W-1:0] ram_din;
logic [1:0]        ram_we;
logic [7:0]        dmp_addr;
logic [7:0]        dmp_din;
logic              halted;
logic              ld_en;
logic [7:0]        ld_addr;
logic [DATA_W-1:0] ld_data;

// one row per test where a pre_idx or mem_idx of 0 means unused
string             name[NTESTS];
logic [DATA_W-1:0] prog[NTESTS][16];
logic [7:0]        pre_idx[NTESTS];
logic [DATA_W-1:0] pre_val[NTESTS];
logic [DATA_W-1:0] exp_reg[NTESTS][NREGS];
logic [3:0]        exp_flags[NTESTS];
logic [7:0]        mem_idx[NTESTS];
logic [DATA_W-1:0] mem_val[NTESTS];

// 0 holds cen low, 1 holds it high, 2 draws it at random
int cen_mode;
int errors;
int runs;
int fails;

cpu900 cpu900_i(
    .clk      ( clk      ), .rst      ( rst      ), .cen      ( cen      ),
    .ram_addr ( ram_addr ), .ram_dout ( ram_dout ), .ram_din  ( ram_din  ),
    .ram_we   ( ram_we   ), .dmp_addr ( dmp_addr ), .dmp_din  ( dmp_din  ),
    .halted   ( halted   )
);

cpu900_mem mem_i(
    .clk      ( clk      ), .cen      ( cen      ), .addr     ( ram_addr ),
    .din      ( ram_din  ), .we       ( ram_we   ), .dout     ( ram_dout ),
    .ld_en    ( ld_en    ), .ld_addr  ( ld_addr  ), .ld_data  ( ld_data  )
);

initial clk = 1'b0;
always #50 clk = ~clk;

function automatic logic [DATA_W-1:0] imm_form(op_e op, logic [2:0] rd, logic [7:0] imm);
    insn_t w;
    w.op  = op;
    w.rsv = 1'b0;
    w.rd  = rd;
    w.imm = imm;
    return w;
endfunction

// rs lives in bits 6 to 4
function automatic logic [DATA_W-1:0] reg_form(op_e op, logic [2:0] rd, logic [2:0] rs);
    return imm_form(op, rd, {1'b0, rs, 4'h0});
endfunction

// inputs change 1 ns after the rising edge
task automatic step();
    @(posedge clk);
    #1;
    case (cen_mode)
        0: cen = 1'b0;
        1: cen = 1'b1;
        default: cen = ($urandom % 4) != 0;
    endcase
endtask

task automatic read_dump(input logic [7:0] a, output logic [7:0] d);
    dmp_addr = a;
    step();
    d = dmp_din;
endtask

task automatic check(string tag, string what, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] got);
    assert (got === exp) else begin
        $display("FAILED %s %s: expected %h, actual %h", tag, what, exp, got);
        errors++;
    end
endtask

task automatic load_memory(int t);
    logic [DATA_W-1:0] w;
    ld_en = 1'b1;
    for (int i = 0; i < 256; i++) begin
        // background built from the whole word index
        w = {~i[7:0], i[7:0]};
        if (i < 16) w = prog[t][i];
        else if (i == int'(pre_idx[t])) w = pre_val[t];
        ld_addr = i[7:0];
        ld_data = w;
        step();
    end
    ld_en = 1'b0;
endtask

task automatic run_test(int t, int mode);
    string      tag;
    logic [7:0] lo;
    logic [7:0] hi;
    int         n;
    tag      = mode == 2 ? {name[t], "_stall"} : name[t];
    errors   = 0;
    cen_mode = 0;
    load_memory(t);
    rst = 1'b1;
    repeat (4) step();
    rst = 1'b0;
    // core frozen by cen so nothing has executed yet
    check(tag, "halted after reset", '0, {15'd0, halted});
    for (int a = 0; a <= 16; a++) begin
        read_dump(a[7:0], lo);
        check(tag, $sformatf("reset dump byte %0d", a), '0, {8'h00, lo});
    end
    cen_mode = mode;
    n = 0;
    while (!halted && n < TIMEOUT) begin
        step();
        n++;
    end
    cen_mode = 0;
    if (!halted) begin
        $display("%s: core did not halt within %0d cycles", tag, TIMEOUT);
        errors++;
    end else begin
        for (int r = 0; r < NREGS; r++) begin
            read_dump(8'(2 * r), lo);
            read_dump(8'(2 * r + 1), hi);
            check(tag, $sformatf("r%0d", r), exp_reg[t][r], {hi, lo});
        end
        read_dump(8'd16, lo);
        check(tag, "flags", {12'h000, exp_flags[t]}, {8'h00, lo});
        if (mem_idx[t] != 8'h00) begin
            check(tag, "memory word", mem_val[t], mem_i.mem[mem_idx[t]]);
        end
    end
    runs++;
    if (errors == 0) begin
        $display("test %s: ok", tag);
    end else begin
        fails++;
        $display("test %s: %0d errors", tag, errors);
    end
endtask

task automatic build_table();
    logic [DATA_W-1:0] h;
    h = imm_form(OP_HALT, 3'd0, 8'h00);
    for (int t = 0; t < NTESTS; t++) begin
        for (int i = 0; i < 16; i++) begin
            prog[t][i] = h;
        end
        pre_idx[t] = 8'h00;
        pre_val[t] = '0;
        mem_idx[t] = 8'h00;
        mem_val[t] = '0;
    end
    name[0]    = "alu_ops";
    prog[0][0] = imm_form(OP_LDI, 3'd1, 8'h5a);
    prog[0][1] = imm_form(OP_LDI, 3'd2, 8'h3c);
    prog[0][2] = imm_form(OP_LDI, 3'd3, 8'hff);
    prog[0][3] = imm_form(OP_LDI, 3'd4, 8'h0f);
    prog[0][4] = reg_form(OP_ADD, 3'd1, 3'd2);
    prog[0][5] = reg_form(OP_SUB, 3'd3, 3'd4);
    prog[0][6] = imm_form(OP_LDI, 3'd5, 8'hcc);
    prog[0][7] = reg_form(OP_AND, 3'd5, 3'd3);
    prog[0][8] = imm_form(OP_LDI, 3'd6, 8'h21);
    prog[0][9] = reg_form(OP_OR, 3'd6, 3'd4);
    prog[0][10] = reg_form(OP_XOR, 3'd2, 3'd4);
    // 0 - 15 borrows and goes negative
    prog[0][11] = reg_form(OP_SUB, 3'd7, 3'd4);
    exp_reg[0] = '{16'h0000, 16'h0096, 16'h0033, 16'h00f0,
                   16'h000f, 16'h00c0, 16'h002f, 16'hfff1};
    exp_flags[0] = 4'b0110;
    name[1]    = "flags_jumps";
    prog[1][0] = imm_form(OP_LDI, 3'd1, 8'h07);
    prog[1][1] = imm_form(OP_LDI, 3'd2, 8'h07);
    prog[1][2] = reg_form(OP_SUB, 3'd1, 3'd2);
    prog[1][3] = imm_form(OP_JRZ, 3'd0, 8'h01);
    prog[1][4] = imm_form(OP_LDI, 3'd3, 8'hee);
    prog[1][5] = imm_form(OP_LDI, 3'd4, 8'h03);
    prog[1][6] = imm_form(OP_LDI, 3'd5, 8'h05);
    prog[1][7] = reg_form(OP_SUB, 3'd4, 3'd5);
    prog[1][8] = imm_form(OP_JRC, 3'd0, 8'h01);
    prog[1][9] = imm_form(OP_LDI, 3'd6, 8'hee);
    // z is clear now so the marker below runs
    prog[1][10] = imm_form(OP_JRZ, 3'd0, 8'h01);
    prog[1][11] = imm_form(OP_LDI, 3'd7, 8'h77);
    // 7 - 5 has no borrow so JRC falls through to the marker
    prog[1][12] = reg_form(OP_SUB, 3'd2, 3'd5);
    prog[1][13] = imm_form(OP_JRC, 3'd0, 8'h01);
    prog[1][14] = imm_form(OP_LDI, 3'd0, 8'h11);
    exp_reg[1] = '{16'h0011, 16'h0000, 16'h0002, 16'h0000,
                   16'hfffe, 16'h0005, 16'h0000, 16'h0077};
    exp_flags[1] = 4'b0000;
    name[2]    = "djnz_loop";
    prog[2][0] = imm_form(OP_LDI, 3'd1, 8'h05);
    prog[2][1] = imm_form(OP_LDI, 3'd2, 8'h03);
    prog[2][2] = reg_form(OP_ADD, 3'd3, 3'd2);
    prog[2][3] = imm_form(OP_DJNZ, 3'd1, 8'hfe);
    prog[2][4] = reg_form(OP_XOR, 3'd4, 3'd4);
    exp_reg[2] = '{16'h0000, 16'h0000, 16'h0003, 16'h000f,
                   16'h0000, 16'h0000, 16'h0000, 16'h0000};
    exp_flags[2] = 4'b1000;
    name[3]    = "store_load";
    prog[3][0] = imm_form(OP_LDI, 3'd1, 8'h40);
    prog[3][1] = reg_form(OP_LD, 3'd2, 3'd1);
    prog[3][2] = imm_form(OP_LDI, 3'd3, 8'h41);
    prog[3][3] = imm_form(OP_LDI, 3'd4, 8'h5a);
    prog[3][4] = reg_form(OP_ADD, 3'd4, 3'd2);
    prog[3][5] = reg_form(OP_ST, 3'd4, 3'd3);
    prog[3][6] = reg_form(OP_LD, 3'd5, 3'd3);
    pre_idx[3] = 8'h40;
    pre_val[3] = 16'hbeef;
    exp_reg[3] = '{16'h0000, 16'h0040, 16'hbeef, 16'h0041,
                   16'hbf49, 16'hbf49, 16'h0000, 16'h0000};
    exp_flags[3] = 4'b0010;
    mem_idx[3] = 8'h41;
    mem_val[3] = 16'hbf49;
endtask

initial begin
    void'($urandom(35999));
    rst      = 1'b1;
    cen      = 1'b0;
    dmp_addr = 8'h00;
    ld_en    = 1'b0;
    ld_addr  = 8'h00;
    ld_data  = '0;
    cen_mode = 0;
    runs     = 0;
    fails    = 0;
    build_table();
    step();
    // first pass holds cen high and the second adds random stalls
    for (int pass = 0; pass < 2; pass++) begin
        for (int t = 0; t < NTESTS; t++) begin
            run_test(t, pass == 0 ? 1 : 2);
        end
    end
    $display("tests run %0d, passed %0d, failed %0d", runs, runs - fails, fails);
    if (fails == 0) begin
        $display("=== PASS ===");
    end else begin
        $display("=== FAIL ===");
    end
    $finish;
end

endmodule

//--- verification/cpu900_mem.sv
// cpu900 test memory with synchronous 16-bit words, byte lanes and a testbench load port
`timescale 1ns/10ps

module cpu900_mem(
    input                                 clk,
    input                                 cen,
    input        [cpu900_pkg::ADDR_W-1:0] addr,
    input        [cpu900_pkg::DATA_W-1:0] din,
    input        [1:0]                    we,
    output logic [cpu900_pkg::DATA_W-1:0] dout,
    // testbench preload that ignores cen
    input                                 ld_en,
    input        [7:0]                    ld_addr,
    input        [cpu900_pkg::DATA_W-1:0] ld_data
);

import cpu900_pkg::*;

// 256 words over byte addresses 0 to 511
logic [DATA_W-1:0] mem[256];
logic [7:0]        widx;

assign widx = addr[8:1];

initial dout = '0;

always @(posedge clk) begin
    if (ld_en) begin
        mem[ld_addr] <= ld_data;
    end else if (cen) begin
        // lane 0 is the low byte
        if (we[0]) mem[widx][7:0] <= din[7:0];
        if (we[1]) mem[widx][15:8] <= din[15:8];
        dout <= mem[widx];
    end
end

endmodule

//--- logic/cpu900.sv
// cpu900 top level connecting controller, register bank, ALU, memory controller and PC
`timescale 1ns/10ps

module cpu900(
    input                                 rst,
    input                                 clk,
    input                                 cen,

    output       [cpu900_pkg::ADDR_W-1:0] ram_addr,
    input        [cpu900_pkg::DATA_W-1:0] ram_dout,
    output       [cpu900_pkg::DATA_W-1:0] ram_din,
    output       [1:0]                    ram_we,
    // register dump
    input        [7:0]                    dmp_addr,
    output       [7:0]                    dmp_din,
    output                                halted
);

import cpu900_pkg::*;

mem_cmd_t          mem_req;
reg_cmd_t          reg_cmd;
alu_op_e           alu_op;
flags_t            flags, nx_flags;
logic              nx_z, pc_inc, pc_we, buf_rdy;
logic [7:0]        offset;
logic [ADDR_W-1:0] pc;
logic [DATA_W-1:0] src_out, dst_out, alu_dout, buf_dout;

cpu900_ctrl u_ctrl(
    .clk      ( clk      ), .rst      ( rst      ), .cen      ( cen      ),
    .op       ( buf_dout ), .op_ok    ( buf_rdy  ),
    .flags    ( flags    ), .nx_z     ( nx_z     ), .src_out  ( src_out  ),
    .mem      ( mem_req  ), .regs     ( reg_cmd  ), .alu_op   ( alu_op   ),
    .pc_inc   ( pc_inc   ), .pc_we    ( pc_we    ), .offset   ( offset   ),
    .halted   ( halted   )
);

cpu900_regs u_regs(
    .clk      ( clk      ), .rst      ( rst      ), .cen      ( cen      ),
    .cmd      ( reg_cmd  ), .alu_dout ( alu_dout ), .mem_dout ( buf_dout ),
    .nx_flags ( nx_flags ), .dmp_addr ( dmp_addr ),
    .src_out  ( src_out  ), .dst_out  ( dst_out  ),
    .flags    ( flags    ), .dmp_din  ( dmp_din  )
);

cpu900_alu u_alu(
    .op0      ( dst_out  ), .op1      ( src_out  ), .sel      ( alu_op   ),
    .dout     ( alu_dout ), .nx_flags ( nx_flags ), .nx_z     ( nx_z     )
);

cpu900_ramctl u_ramctl(
    .clk      ( clk      ), .rst      ( rst      ), .cen      ( cen      ),
    .pc       ( pc       ), .req      ( mem_req  ), .wdata    ( dst_out  ),
    .ram_dout ( ram_dout ), .ram_addr ( ram_addr ), .ram_din  ( ram_din  ),
    .ram_we   ( ram_we   ), .dout     ( buf_dout ), .ram_rdy  ( buf_rdy  )
);

cpu900_pc u_pc(
    .clk      ( clk      ), .rst      ( rst      ), .cen      ( cen      ),
    .inc      ( pc_inc   ), .we       ( pc_we    ), .offset   ( offset   ),
    .pc       ( pc       )
);

endmodule

//--- logic/cpu900_ctrl.sv
// cpu900 controller that sequences fetch, decode and execute for regs, ALU, memory and PC
`timescale 1ns/10ps

module cpu900_ctrl(
    input                               clk,
    input                               rst,
    input                               cen,
    input  cpu900_pkg::insn_t           op,
    input                               op_ok,
    input  cpu900_pkg::flags_t          flags,
    input                               nx_z,
    input        [cpu900_pkg::DATA_W-1:0] src_out,
    output cpu900_pkg::mem_cmd_t        mem,
    output cpu900_pkg::reg_cmd_t        regs,
    output cpu900_pkg::alu_op_e         alu_op,
    output logic                        pc_inc,
    output logic                        pc_we,
    output       [7:0]                  offset,
    output                              halted
);

import cpu900_pkg::*;

state_e            state, nx_state;
insn_t             insn;
logic [ADDR_W-1:0] addr_q;
logic              mem_wait, nx_wait;

assign offset = insn.imm;
assign halted = state == ST_HALT;

always_ff @(posedge clk) begin
    if (rst) begin
        state    <= ST_FETCH;
        mem_wait <= 1'b0;
    end else if (cen) begin
        state    <= nx_state;
        mem_wait <= nx_wait;
    end
end

// instruction and data address latches
always_ff @(posedge clk) begin
    if (cen) begin
        if (state == ST_DECODE && op_ok) insn <= op;
        // word pointer to byte address
        if (state == ST_EXEC) addr_q <= {{(ADDR_W-DATA_W-1){1'b0}}, src_out, 1'b0};
    end
end

always_comb begin
    nx_state = state;
    nx_wait  = mem_wait;
    mem      = '0;
    mem.addr = addr_q;
    regs     = '0;
    regs.dst = insn.rd;
    regs.src = insn.imm[6:4];
    alu_op   = ALU_ADD;
    pc_inc   = 1'b0;
    pc_we    = 1'b0;
    case (state)
        ST_FETCH: begin
            mem.fetch = 1'b1;
            nx_state  = ST_DECODE;
        end
        ST_DECODE: begin
            if (op_ok) begin
                pc_inc   = 1'b1;
                nx_state = ST_EXEC;
            end
        end
        ST_EXEC: begin
            nx_state = ST_FETCH;
            case (insn.op)
                OP_LDI: begin
                    regs.we      = 1'b1;
                    regs.sel_mem = 1'b1;
                    regs.sel_imm = 1'b1;
                end
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                    regs.we      = 1'b1;
                    regs.flag_we = 1'b1;
                    case (insn.op)
                        OP_SUB:  alu_op = ALU_SUB;
                        OP_AND:  alu_op = ALU_AND;
                        OP_OR:   alu_op = ALU_OR;
                        OP_XOR:  alu_op = ALU_XOR;
                        default: alu_op = ALU_ADD;
                    endcase
                end
                OP_LD, OP_ST: nx_state = ST_MEM;
                OP_JR:  pc_we = 1'b1;
                OP_JRZ: pc_we = flags.z;
                OP_JRC: pc_we = flags.c;
                OP_DJNZ: begin
                    // counter write and branch test in the same cycle
                    alu_op  = ALU_DEC;
                    regs.we = 1'b1;
                    pc_we   = ~nx_z;
                end
                OP_HALT: nx_state = ST_HALT;
                default: ;
            endcase
        end
        ST_MEM: begin
            if (insn.op == OP_ST) begin
                mem.wr   = 1'b1;
                nx_state = ST_FETCH;
            end else if (!mem_wait) begin
                mem.rd  = 1'b1;
                nx_wait = 1'b1;
            end else if (op_ok) begin
                regs.we      = 1'b1;
                regs.sel_mem = 1'b1;
                nx_wait      = 1'b0;
                nx_state     = ST_FETCH;
            end
        end
        default: ;
    endcase
end

endmodule

//--- logic/cpu900_ramctl.sv
// cpu900 memory controller for instruction fetch, data read and data write on the external port
`timescale 1ns/10ps

module cpu900_ramctl(
    input                                 clk,
    input                                 rst,
    input                                 cen,
    input        [cpu900_pkg::ADDR_W-1:0] pc,
    input  cpu900_pkg::mem_cmd_t          req,
    input        [cpu900_pkg::DATA_W-1:0] wdata,
    input        [cpu900_pkg::DATA_W-1:0] ram_dout,
    output       [cpu900_pkg::ADDR_W-1:0] ram_addr,
    output       [cpu900_pkg::DATA_W-1:0] ram_din,
    output       [1:0]                    ram_we,
    output       [cpu900_pkg::DATA_W-1:0] dout,
    output                                ram_rdy
);

import cpu900_pkg::*;

logic              pend;
logic [DATA_W-1:0] dout_q;

// data accesses take the latched pointer and everything else follows the PC
assign ram_addr = (req.rd || req.wr) ? req.addr : pc;
assign ram_din  = wdata;
assign ram_we   = req.wr ? 2'b11 : 2'b00;

// one enabled cycle of read latency
always_ff @(posedge clk) begin
    if (rst) begin
        pend <= 1'b0;
    end else if (cen) begin
        pend <= req.fetch | req.rd;
    end
end

// holds the last word so LDI can still see its own opcode
always_ff @(posedge clk) begin
    if (cen && pend) dout_q <= ram_dout;
end

assign ram_rdy = pend;
assign dout    = pend ? ram_dout : dout_q;

endmodule

//--- logic/cpu900_pc.sv
// cpu900 program counter with word step on fetch and signed relative branch
`timescale 1ns/10ps

module cpu900_pc(
    input                                 clk,
    input                                 rst,
    input                                 cen,
    input                                 inc,
    input                                 we,
    input        [7:0]                    offset,
    output logic [cpu900_pkg::ADDR_W-1:0] pc
);

import cpu900_pkg::*;

logic [ADDR_W-1:0] rel;

// offset counts words while pc counts bytes
assign rel = {{(ADDR_W-9){offset[7]}}, offset, 1'b0};

always_ff @(posedge clk) begin
    if (rst) begin
        pc <= '0;
    end else if (cen) begin
        if (inc) pc <= pc + ADDR_W'(2);
        else if (we) pc <= pc + rel;
    end
end

endmodule

//--- logic/cpu900_regs.sv
// cpu900 register bank with eight general registers, flags and a byte-wide dump view
`timescale 1ns/10ps

module cpu900_regs(
    input                                 clk,
    input                                 rst,
    input                                 cen,
    input  cpu900_pkg::reg_cmd_t          cmd,
    input        [cpu900_pkg::DATA_W-1:0] alu_dout,
    input        [cpu900_pkg::DATA_W-1:0] mem_dout,
    input  cpu900_pkg::flags_t            nx_flags,
    input        [7:0]                    dmp_addr,
    output       [cpu900_pkg::DATA_W-1:0] src_out,
    output       [cpu900_pkg::DATA_W-1:0] dst_out,
    output cpu900_pkg::flags_t            flags,
    output logic [7:0]                    dmp_din
);

import cpu900_pkg::*;

logic [DATA_W-1:0] r[NREGS];
logic [DATA_W-1:0] wdata;
logic [DATA_W-1:0] dmp_reg;

assign src_out = r[cmd.src];
assign dst_out = r[cmd.dst];

always_comb begin
    if (!cmd.sel_mem) wdata = alu_dout;
    else if (cmd.sel_imm) wdata = {8'h00, mem_dout[7:0]};
    else wdata = mem_dout;
end

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < NREGS; i++) begin
            r[i] <= '0;
        end
        flags <= '0;
    end else if (cen) begin
        if (cmd.we) r[cmd.dst] <= wdata;
        if (cmd.flag_we) flags <= nx_flags;
    end
end

// bytes 0 to 15 map the registers low byte first and 16 is the flag byte
assign dmp_reg = r[dmp_addr[3:1]];

always_comb begin
    dmp_din = 8'h00;
    if (dmp_addr[7:4] == 4'd0) begin
        dmp_din = dmp_addr[0] ? dmp_reg[15:8] : dmp_reg[7:0];
    end else if (dmp_addr == 8'd16) begin
        dmp_din = {4'd0, flags};
    end
end

endmodule

//--- logic/cpu900_alu.sv
// cpu900 ALU computing 16-bit arithmetic and logic results with next flags
`timescale 1ns/10ps

module cpu900_alu(
    input        [cpu900_pkg::DATA_W-1:0] op0,
    input        [cpu900_pkg::DATA_W-1:0] op1,
    input  cpu900_pkg::alu_op_e           sel,
    output logic [cpu900_pkg::DATA_W-1:0] dout,
    output cpu900_pkg::flags_t            nx_flags,
    output                                nx_z
);

import cpu900_pkg::*;

logic [DATA_W-1:0] b;
logic [DATA_W:0]   sum;
logic              carry;
logic              ovf;

// decrement is a subtract of one
assign b = (sel == ALU_DEC) ? 16'd1 : op1;

always_comb begin
    sum   = '0;
    dout  = '0;
    carry = 1'b0;
    ovf   = 1'b0;
    case (sel)
        ALU_ADD: begin
            sum   = {1'b0, op0} + {1'b0, b};
            dout  = sum[DATA_W-1:0];
            carry = sum[DATA_W];
            ovf   = (op0[15] == b[15]) && (dout[15] != op0[15]);
        end
        ALU_SUB, ALU_DEC: begin
            sum   = {1'b0, op0} - {1'b0, b};
            dout  = sum[DATA_W-1:0];
            // top bit of the 17-bit difference is the borrow
            carry = sum[DATA_W];
            ovf   = (op0[15] != b[15]) && (dout[15] != op0[15]);
        end
        ALU_AND: dout = op0 & b;
        ALU_OR:  dout = op0 | b;
        ALU_XOR: dout = op0 ^ b;
        default: dout = op0;
    endcase
end

always_comb begin
    nx_flags.z = dout == '0;
    nx_flags.c = carry;
    nx_flags.s = dout[15];
    nx_flags.v = ovf;
end

assign nx_z = nx_flags.z;

endmodule

//--- logic/cpu900_pkg.sv
// cpu900 shared widths, opcode and state encodings, and bundled command types
package cpu900_pkg;

    // external bus widths
    localparam int ADDR_W = 24;
    localparam int DATA_W = 16;

    // general registers r0 to r7
    localparam int NREGS = 8;

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_LDI  = 4'h1,
        OP_ADD  = 4'h2,
        OP_SUB  = 4'h3,
        OP_AND  = 4'h4,
        OP_OR   = 4'h5,
        OP_XOR  = 4'h6,
        OP_LD   = 4'h7,
        OP_ST   = 4'h8,
        OP_JR   = 4'h9,
        OP_JRZ  = 4'ha,
        OP_JRC  = 4'hb,
        OP_DJNZ = 4'hc,
        OP_HALT = 4'hf
    } op_e;

    // rs sits in imm[6:4] for register forms
    typedef struct packed {
        op_e        op;
        logic       rsv;
        logic [2:0] rd;
        logic [7:0] imm;
    } insn_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_DEC
    } alu_op_e;

    // z is the msb as in the dump byte
    typedef struct packed {
        logic z;
        logic c;
        logic s;
        logic v;
    } flags_t;

    typedef struct packed {
        logic       we;
        logic [2:0] dst;
        logic [2:0] src;
        logic       sel_mem;
        logic       sel_imm;    // zero-extended low byte of the memory word
        logic       flag_we;
    } reg_cmd_t;

    typedef struct packed {
        logic              fetch;
        logic              rd;
        logic              wr;
        logic [ADDR_W-1:0] addr;
    } mem_cmd_t;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXEC,
        ST_MEM,
        ST_HALT
    } state_e;

endpackage
